// File: include/itag_defs.svh
// Geometry of the 4-way tag store; tag + index + offset must sum to 32, depth = 2**index width
`ifndef ITAG_DEFS_SVH
`define ITAG_DEFS_SVH

// Associativity
`define ITAG_N_WAY 4

// Fetch address split, MSB first
`define ITAG_TAG_WIDTH 20
`define ITAG_INDEX_WIDTH 6
`define ITAG_OFFSET_WIDTH 6

// One SRAM word per set
`define ITAG_DEPTH 64

// Hit and miss counters, saturating
`define ITAG_CNT_WIDTH 16

`endif

// File: logic/icache_types_pkg.sv
// Address and way types of the tag store; way_idx_t assumes a power-of-two way count
package icache_types_pkg;

  `include "itag_defs.svh"

  typedef logic [`ITAG_TAG_WIDTH-1:0]    tag_t;       // One way tag
  typedef logic [`ITAG_INDEX_WIDTH-1:0]  index_t;     // Set number
  typedef logic [`ITAG_OFFSET_WIDTH-1:0] offset_t;    // Byte in line, unused by tag side
  typedef logic [`ITAG_N_WAY-1:0]        way_mask_t;  // One bit per way
  typedef logic [$clog2(`ITAG_N_WAY)-1:0] way_idx_t;  // Binary way number

  // Field view of a fetch address
  typedef struct packed {
    tag_t    tag;     // Upper bits
    index_t  index;   // Selects the set
    offset_t offset;  // Ignored here
  } fetch_fields_t;

  // Same word, either raw from the fetch unit or split into fields
  typedef union packed {
    logic [`ITAG_TAG_WIDTH+`ITAG_INDEX_WIDTH+`ITAG_OFFSET_WIDTH-1:0] raw;
    fetch_fields_t                                                   f;
  } fetch_addr_u;

endpackage

// File: logic/icache_cfg_pkg.sv
// Configuration map of the tag store; selector 3 is unmapped and reads as zero
package icache_cfg_pkg;

  `include "itag_defs.svh"

  // Register selector
  typedef enum logic [1:0] {
    CFG_WAY_EN   = 2'd0,  // Way-enable mask, resets to all ones
    CFG_HIT_CNT  = 2'd1,  // Hit count, any write clears
    CFG_MISS_CNT = 2'd2   // Miss count, any write clears
  } cfg_addr_e;

  // Counter and configuration data word
  typedef logic [`ITAG_CNT_WIDTH-1:0] counter_t;

endpackage

// File: logic/itag_mem_if.sv
// Tag memory port; one operation per cycle, read data and valid bits arrive one cycle later
`timescale 1ns/10ps
`include "itag_defs.svh"

interface itag_mem_if;

  icache_types_pkg::way_mask_t                  req;       // Ways taking part
  logic                                         we;        // Write, else read
  logic                                         vbit;      // Valid bit to write
  logic                                         flush;     // Clear all valid bits
  icache_types_pkg::tag_t                       wdata;     // Tag to write
  icache_types_pkg::index_t                     addr;      // Set number
  icache_types_pkg::tag_t [`ITAG_N_WAY-1:0]     tag_way;   // Stored tags, way 0 in low bits
  icache_types_pkg::way_mask_t                  vbit_way;  // Stored valid bits

  // Lookup controller side
  modport ctrl (
    output req, we, vbit, flush, wdata, addr,
    input  tag_way, vbit_way
  );

  // Memory side
  modport mem (
    input  req, we, vbit, flush, wdata, addr,
    output tag_way, vbit_way
  );

endinterface

// File: logic/tag_sram_model.sv
// Behavioral single-port SRAM, no reset, contents X until written, read data held between reads
`timescale 1ns/10ps
`include "itag_defs.svh"

module tag_sram_model (
  input  logic                                       clk_i,
  input  logic                                       ce_n_i,     // Chip enable, active low
  input  logic                                       we_n_i,     // Write when low
  input  logic [`ITAG_INDEX_WIDTH-1:0]               addr_i,
  input  logic [`ITAG_N_WAY*`ITAG_TAG_WIDTH-1:0]     wdata_i,
  input  logic [`ITAG_N_WAY*`ITAG_TAG_WIDTH-1:0]     wmask_n_i,  // Low bits get written
  output logic [`ITAG_N_WAY*`ITAG_TAG_WIDTH-1:0]     rdata_o
);

  localparam int unsigned WordW = `ITAG_N_WAY*`ITAG_TAG_WIDTH;

  logic [WordW-1:0] mem_q [`ITAG_DEPTH];  // Array body
  logic [WordW-1:0] merged;               // Old word with new bits overlaid

  // Keep masked-off bits, take data where mask is low
  assign merged = (mem_q[addr_i] & wmask_n_i) | (wdata_i & ~wmask_n_i);

  always_ff @(posedge clk_i) begin
    if (!ce_n_i) begin
      if (!we_n_i) begin
        mem_q[addr_i] <= merged;  // Bit-masked write
      end else begin
        rdata_o <= mem_q[addr_i];  // Registered read
      end
    end
  end

endmodule

// File: logic/itag_memory.sv
// Tag store of one set per word; flush wins over any write, valid read is reset, tags are not
`timescale 1ns/10ps
`include "itag_defs.svh"

module itag_memory (
  input  logic   clk_i,
  input  logic   rst_n_i,
  itag_mem_if.mem mem
);

  localparam int unsigned TagW  = `ITAG_TAG_WIDTH;
  localparam int unsigned WordW = `ITAG_N_WAY*`ITAG_TAG_WIDTH;

  logic [`ITAG_DEPTH-1:0]       vbit_q [`ITAG_N_WAY];  // Valid bits per way, per set
  icache_types_pkg::way_mask_t  vbit_rd_q;             // Registered valid read

  logic [WordW-1:0] way_mask;    // Requested ways widened to tag bits
  logic [WordW-1:0] sram_wdata;  // Tag copied into every way slot
  logic [WordW-1:0] sram_wmask_n;
  logic [WordW-1:0] sram_rdata;
  logic             sram_ce_n;
  logic             sram_we_n;

  // Valid bit arrays, flush clears the whole cache at once
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || mem.flush) begin
      vbit_q <= '{default: '0};
    end else if (mem.we) begin
      for (int w = 0; w < `ITAG_N_WAY; w++) begin
        if (mem.req[w]) vbit_q[w][mem.addr] <= mem.vbit;  // Only selected ways
      end
    end
  end

  // Valid bits read alongside the tag word
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vbit_rd_q <= '0;
    end else if (!mem.we) begin
      for (int w = 0; w < `ITAG_N_WAY; w++) begin
        if (mem.req[w]) vbit_rd_q[w] <= vbit_q[w][mem.addr];
      end
    end
  end

  // Widen the way request into a per-bit mask
  for (genvar w = 0; w < `ITAG_N_WAY; w++) begin : g_mask
    assign way_mask[w*TagW +: TagW] = {TagW{mem.req[w]}};
  end

  assign sram_wdata   = {`ITAG_N_WAY{mem.wdata}};   // Same tag in each slot
  assign sram_wmask_n = ~({WordW{mem.we}} & way_mask);  // Write only requested slots
  assign sram_we_n    = ~mem.we;
  assign sram_ce_n    = ~(|mem.req);                 // Idle when no way asked for

  tag_sram_model u_tag_sram (
    .clk_i     (clk_i),
    .ce_n_i    (sram_ce_n),
    .we_n_i    (sram_we_n),
    .addr_i    (mem.addr),
    .wdata_i   (sram_wdata),
    .wmask_n_i (sram_wmask_n),
    .rdata_o   (sram_rdata)
  );

  assign mem.tag_way  = sram_rdata;  // Way 0 in bits 19:0 upward
  assign mem.vbit_way = vbit_rd_q;

endmodule

// File: logic/itag_lookup_ctrl.sv
// Lookup sequencer; flush beats fill beats lookup, a dropped lookup gives no done pulse
`timescale 1ns/10ps
`include "itag_defs.svh"

module itag_lookup_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          lookup_valid_i,
  input  icache_types_pkg::fetch_addr_u lookup_addr_i,
  input  logic                          fill_valid_i,
  input  icache_types_pkg::fetch_addr_u fill_addr_i,
  input  logic                          flush_i,
  input  icache_types_pkg::way_mask_t   way_en_i,
  input  icache_types_pkg::way_mask_t   victim_way_i,   // One-hot or zero
  itag_mem_if.ctrl                      mem,
  output logic                          lookup_done_o,
  output logic                          hit_o,
  output logic                          miss_o,
  output icache_types_pkg::way_idx_t    hit_way_o,
  output logic                          capture_o,      // Victim capture strobe
  output icache_types_pkg::way_mask_t   set_valid_o
);

  logic                         do_lookup;  // Lookup survives priority
  logic                         done_q;     // Read data valid this cycle
  icache_types_pkg::tag_t       tag_q;      // Tag under compare
  icache_types_pkg::way_mask_t  hit_vec;    // Raw per-way match
  icache_types_pkg::way_idx_t   hit_way;

  assign do_lookup = lookup_valid_i & ~flush_i & ~fill_valid_i;

  // Memory request, one operation per cycle
  always_comb begin
    mem.req   = '0;
    mem.we    = 1'b0;
    mem.vbit  = 1'b0;
    mem.flush = 1'b0;
    mem.wdata = fill_addr_i.f.tag;
    mem.addr  = lookup_addr_i.f.index;
    if (flush_i) begin
      mem.flush = 1'b1;                     // All valid bits go
    end else if (fill_valid_i) begin
      mem.req  = victim_way_i;              // Zero when no way enabled
      mem.we   = 1'b1;
      mem.vbit = 1'b1;
      mem.addr = fill_addr_i.f.index;
    end else if (lookup_valid_i) begin
      mem.req = '1;                         // Whole set at once
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) done_q <= 1'b0;
    else          done_q <= do_lookup;
  end

  always_ff @(posedge clk_i) begin
    if (do_lookup) tag_q <= lookup_addr_i.f.tag;  // Payload, no reset
  end

  // Match needs stored valid and current enable
  always_comb begin
    hit_vec = '0;
    for (int w = 0; w < `ITAG_N_WAY; w++) begin
      hit_vec[w] = mem.vbit_way[w] & way_en_i[w] & (mem.tag_way[w] == tag_q);
    end
  end

  // Lowest matching way wins
  always_comb begin
    hit_way = '0;
    for (int w = `ITAG_N_WAY-1; w >= 0; w--) begin
      if (hit_vec[w]) hit_way = icache_types_pkg::way_idx_t'(w);
    end
  end

  assign lookup_done_o = done_q;
  assign hit_o         = done_q & (|hit_vec);
  assign miss_o        = done_q & ~(|hit_vec);
  assign hit_way_o     = hit_way;
  assign capture_o     = miss_o;           // Victim chosen on every miss
  assign set_valid_o   = mem.vbit_way;

endmodule

// File: logic/itag_victim_select.sv
// Replacement way; invalid enabled ways first, then round robin, zero when no way is enabled
`timescale 1ns/10ps
`include "itag_defs.svh"

module itag_victim_select (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        capture_i,     // Miss seen
  input  icache_types_pkg::way_mask_t set_valid_i,   // Valid bits of missed set
  input  icache_types_pkg::way_mask_t way_en_i,
  output icache_types_pkg::way_mask_t victim_way_o   // One-hot, held to next miss
);

  icache_types_pkg::way_idx_t  ptr_q;      // Last chosen way
  icache_types_pkg::way_idx_t  pick;
  icache_types_pkg::way_idx_t  cand;       // Round-robin candidate
  icache_types_pkg::way_mask_t free_ways;  // Enabled and invalid
  icache_types_pkg::way_mask_t victim_q;
  logic                        found;

  always_comb begin
    free_ways = way_en_i & ~set_valid_i;
    pick      = ptr_q;
    found     = 1'b0;
    cand      = ptr_q;
    // Lowest free way, scanned downward so the last hit is the lowest
    for (int w = `ITAG_N_WAY-1; w >= 0; w--) begin
      if (free_ways[w]) begin
        pick  = icache_types_pkg::way_idx_t'(w);
        found = 1'b1;
      end
    end
    // Set full, nearest enabled way after the pointer
    if (!found) begin
      for (int k = `ITAG_N_WAY; k >= 1; k--) begin
        cand = icache_types_pkg::way_idx_t'(ptr_q + k);  // Wraps at way count
        if (way_en_i[cand]) begin
          pick  = cand;
          found = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q    <= icache_types_pkg::way_idx_t'(`ITAG_N_WAY-1);  // First pick is way 0
      victim_q <= '0;
    end else if (capture_i) begin
      if (found) begin
        victim_q <= icache_types_pkg::way_mask_t'(1) << pick;
        ptr_q    <= pick;                                      // Any choice moves it
      end else begin
        victim_q <= '0;  // Nothing enabled, fill is a no-op
      end
    end
  end

  assign victim_way_o = victim_q;

endmodule

// File: logic/itag_cfg_regs.sv
// Way enable and saturating counters; a write clears a counter whatever the data, reads are live
`timescale 1ns/10ps
`include "itag_defs.svh"

module itag_cfg_regs (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        cfg_we_i,
  input  icache_cfg_pkg::cfg_addr_e   cfg_addr_i,
  input  icache_cfg_pkg::counter_t    cfg_wdata_i,
  output icache_cfg_pkg::counter_t    cfg_rdata_o,
  input  logic                        hit_i,      // One pulse per hit
  input  logic                        miss_i,     // One pulse per miss
  output icache_types_pkg::way_mask_t way_en_o
);

  icache_types_pkg::way_mask_t way_en_q;
  icache_cfg_pkg::counter_t    hit_cnt_q;
  icache_cfg_pkg::counter_t    miss_cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      way_en_q   <= '1;  // All ways usable
      hit_cnt_q  <= '0;
      miss_cnt_q <= '0;
    end else begin
      if (cfg_we_i && cfg_addr_i == icache_cfg_pkg::CFG_WAY_EN) begin
        way_en_q <= cfg_wdata_i[`ITAG_N_WAY-1:0];  // Low bits only
      end
      if (cfg_we_i && cfg_addr_i == icache_cfg_pkg::CFG_HIT_CNT) begin
        hit_cnt_q <= '0;  // Clear beats a same-cycle hit
      end else if (hit_i && hit_cnt_q != '1) begin
        hit_cnt_q <= hit_cnt_q + 1'b1;
      end
      if (cfg_we_i && cfg_addr_i == icache_cfg_pkg::CFG_MISS_CNT) begin
        miss_cnt_q <= '0;
      end else if (miss_i && miss_cnt_q != '1) begin
        miss_cnt_q <= miss_cnt_q + 1'b1;
      end
    end
  end

  // Read mux
  always_comb begin
    case (cfg_addr_i)
      icache_cfg_pkg::CFG_WAY_EN:   cfg_rdata_o = icache_cfg_pkg::counter_t'(way_en_q);
      icache_cfg_pkg::CFG_HIT_CNT:  cfg_rdata_o = hit_cnt_q;
      icache_cfg_pkg::CFG_MISS_CNT: cfg_rdata_o = miss_cnt_q;
      default:                      cfg_rdata_o = '0;  // Unmapped
    endcase
  end

  assign way_en_o = way_en_q;

endmodule

// File: logic/itag_lookup_top.sv
// Tag side of the 4-way I-cache; strobes are single cycle with no back-pressure, no data array
`timescale 1ns/10ps
`include "itag_defs.svh"

module itag_lookup_top (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          lookup_valid_i,
  input  logic [$bits(icache_types_pkg::fetch_addr_u)-1:0] lookup_addr_i,
  input  logic                                          fill_valid_i,
  input  logic [$bits(icache_types_pkg::fetch_addr_u)-1:0] fill_addr_i,
  input  logic                                          flush_i,
  input  logic                                          cfg_we_i,
  input  logic [$bits(icache_cfg_pkg::cfg_addr_e)-1:0]  cfg_addr_i,
  input  logic [`ITAG_CNT_WIDTH-1:0]                    cfg_wdata_i,
  output logic [`ITAG_CNT_WIDTH-1:0]                    cfg_rdata_o,
  output logic                                          lookup_done_o,
  output logic                                          hit_o,
  output logic                                          miss_o,
  output logic [$clog2(`ITAG_N_WAY)-1:0]                hit_way_o
);

  icache_types_pkg::fetch_addr_u lookup_addr;  // Raw view filled from port
  icache_types_pkg::fetch_addr_u fill_addr;
  icache_types_pkg::way_mask_t   way_en;       // From config to ctrl and selector
  icache_types_pkg::way_mask_t   victim_way;
  icache_types_pkg::way_mask_t   set_valid;    // Missed set's valid bits
  logic                          capture;

  assign lookup_addr.raw = lookup_addr_i;
  assign fill_addr.raw   = fill_addr_i;

  itag_mem_if mem_if ();

  itag_memory u_memory (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .mem     (mem_if)
  );

  itag_lookup_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .lookup_valid_i (lookup_valid_i),
    .lookup_addr_i  (lookup_addr),
    .fill_valid_i   (fill_valid_i),
    .fill_addr_i    (fill_addr),
    .flush_i        (flush_i),
    .way_en_i       (way_en),
    .victim_way_i   (victim_way),
    .mem            (mem_if),
    .lookup_done_o  (lookup_done_o),
    .hit_o          (hit_o),
    .miss_o         (miss_o),
    .hit_way_o      (hit_way_o),
    .capture_o      (capture),
    .set_valid_o    (set_valid)
  );

  itag_victim_select u_victim (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .capture_i    (capture),
    .set_valid_i  (set_valid),
    .way_en_i     (way_en),
    .victim_way_o (victim_way)
  );

  itag_cfg_regs u_cfg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (icache_cfg_pkg::cfg_addr_e'(cfg_addr_i)),  // Bus bits to selector
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .hit_i       (hit_o),
    .miss_i      (miss_o),
    .way_en_o    (way_en)
  );

endmodule

// File: verification/itag_lookup_props.sv
// Controller checks; bound to every itag_lookup_ctrl instance, reset is synchronous active low
`timescale 1ns/10ps

module itag_lookup_props (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        lookup_valid_i,
  input logic                        fill_valid_i,
  input logic                        flush_i,
  input logic                        lookup_done_o,
  input logic                        hit_o,
  input logic                        miss_o,
  input icache_types_pkg::way_mask_t hit_vec
);

  logic        accepted;      // Lookup that survives flush and fill
  int unsigned fail_cnt = 0;  // Failed assertions so far

  assign accepted = lookup_valid_i & ~fill_valid_i & ~flush_i;

  // Done exactly one cycle after an accepted lookup
  a_done_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accepted |=> lookup_done_o) else begin
    $error("done missing after accepted lookup");
    fail_cnt++;
  end

  a_done_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !accepted |=> !lookup_done_o) else begin
    $error("done without accepted lookup");
    fail_cnt++;
  end

  a_flags_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(hit_o && miss_o)) else begin
    $error("hit and miss together");
    fail_cnt++;
  end

  a_flags_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !lookup_done_o |-> (!hit_o && !miss_o)) else begin
    $error("flag without done");
    fail_cnt++;
  end

  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lookup_done_o |-> $onehot0(hit_vec)) else begin
    $error("several ways hit");
    fail_cnt++;
  end

  // Reset leaves outputs quiet until a lookup arrives
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> (!lookup_done_o && !hit_o && !miss_o)) else begin
    $error("outputs active after reset");
    fail_cnt++;
  end

endmodule

bind itag_lookup_ctrl itag_lookup_props u_props (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .lookup_valid_i (lookup_valid_i),
  .fill_valid_i   (fill_valid_i),
  .flush_i        (flush_i),
  .lookup_done_o  (lookup_done_o),
  .hit_o          (hit_o),
  .miss_o         (miss_o),
  .hit_vec        (hit_vec)
);

// File: verification/itag_lookup_tb.sv
// Directed table, then 200 LCG lookups over sets 0 to 3 with refills; stops at first mismatch
`timescale 1ns/10ps
`include "itag_defs.svh"

module itag_lookup_tb;

  localparam int OP_LOOKUP = 0;
  localparam int OP_FILL   = 1;
  localparam int OP_FLUSH  = 2;
  localparam int OP_CFG_WR = 3;  // data[17:16] selector, data[15:0] value
  localparam int OP_CFG_RD = 4;

  logic clk_i = 1'b0;
  logic rst_n_i, lookup_valid_i, fill_valid_i, flush_i, cfg_we_i;
  logic [31:0] lookup_addr_i, fill_addr_i;
  logic [1:0] cfg_addr_i;
  logic [`ITAG_CNT_WIDTH-1:0] cfg_wdata_i, cfg_rdata_o;
  logic lookup_done_o, hit_o, miss_o;
  logic [1:0] hit_way_o;

  int row_op[$];
  logic [31:0] row_data[$];
  logic row_hit[$];
  icache_types_pkg::way_idx_t row_way[$];
  icache_cfg_pkg::counter_t row_rd[$];

  // Reference state
  icache_types_pkg::tag_t    m_tag [`ITAG_DEPTH][`ITAG_N_WAY];
  icache_types_pkg::way_mask_t m_vld [`ITAG_DEPTH];
  icache_types_pkg::way_mask_t m_en, m_victim;
  icache_types_pkg::way_idx_t  m_ptr;
  icache_cfg_pkg::counter_t    m_hits, m_misses;
  logic [31:0] seed;

  itag_lookup_top DUT (.*);

  initial begin
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] mk_addr(input icache_types_pkg::tag_t t,
                                          input icache_types_pkg::index_t i);
    icache_types_pkg::fetch_addr_u u;
    u.f.tag = t;
    u.f.index = i;
    u.f.offset = 6'h2a;  // Offset must not matter
    return u.raw;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic fail_value(input string msg);
    abort_run($sformatf("ERROR at %0t ns: %s", $time, msg));
  endtask

  task automatic check_way(input icache_types_pkg::way_idx_t got,
                           input icache_types_pkg::way_idx_t exp);
    if (got !== exp) fail_value($sformatf("hit_way_o %0d, expected %0d", got, exp));
  endtask

  task automatic check_flags(input logic hit, input logic miss, input logic exp_hit);
    if (hit !== exp_hit || miss !== !exp_hit)
      fail_value($sformatf("hit %b miss %b, expected hit %b", hit, miss, exp_hit));
  endtask

  task automatic check_count(input icache_cfg_pkg::counter_t got,
                             input icache_cfg_pkg::counter_t exp);
    if (got !== exp) fail_value($sformatf("cfg_rdata_o %0h, expected %0h", got, exp));
  endtask

  task automatic add_row(input int op, input logic [31:0] data, input logic hit,
                         input icache_types_pkg::way_idx_t way,
                         input icache_cfg_pkg::counter_t rd);
    row_op.push_back(op);
    row_data.push_back(data);
    row_hit.push_back(hit);
    row_way.push_back(way);
    row_rd.push_back(rd);
  endtask

  // Model of one lookup, victim choice included
  task automatic model_lookup(input logic [31:0] a, output logic hit,
                              output icache_types_pkg::way_idx_t way);
    icache_types_pkg::fetch_addr_u u;
    icache_types_pkg::way_mask_t hv, free;
    icache_types_pkg::way_idx_t c;
    logic found;
    u.raw = a;
    hv = '0;
    for (int w = 0; w < 4; w++)
      hv[w] = m_vld[u.f.index][w] && m_en[w] && m_tag[u.f.index][w] == u.f.tag;
    hit = |hv;
    way = 0;
    for (int w = 3; w >= 0; w--) begin
      if (hv[w]) way = w;  // Lowest hitting way
    end
    if (hit) begin
      m_hits++;
    end else begin
      m_misses++;
      free = m_en & ~m_vld[u.f.index];
      found = 1'b0;
      for (int w = 0; w < 4; w++) begin
        if (!found && free[w]) begin
          c = w;
          found = 1'b1;
        end
      end
      for (int k = 1; k <= 4; k++) begin
        if (!found && m_en[2'(m_ptr + k)]) begin
          c = 2'(m_ptr + k);  // Round robin after last pick
          found = 1'b1;
        end
      end
      if (found) begin
        m_victim = 4'b1 << c;
        m_ptr = c;
      end else begin
        m_victim = '0;
      end
    end
  endtask

  task automatic model_fill(input logic [31:0] a);
    icache_types_pkg::fetch_addr_u u;
    u.raw = a;
    for (int w = 0; w < 4; w++) begin
      if (m_victim[w]) begin
        m_tag[u.f.index][w] = u.f.tag;
        m_vld[u.f.index][w] = 1'b1;
      end
    end
  endtask

  task automatic wait_done();
    int cnt;
    cnt = 0;
    while (!lookup_done_o) begin
      if (cnt == 10) abort_run("Timeout: lookup_done_o never rose after a lookup");
      @(posedge clk_i);
      #1;
      cnt++;
    end
  endtask

  task automatic apply(input int op, input logic [31:0] data, input logic exp_hit,
                       input icache_types_pkg::way_idx_t exp_way,
                       input icache_cfg_pkg::counter_t exp_rd);
    logic mh;
    icache_types_pkg::way_idx_t mw;
    case (op)
      OP_LOOKUP: begin
        lookup_addr_i = data;
        lookup_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        lookup_valid_i = 1'b0;
        wait_done();
        model_lookup(data, mh, mw);  // Also updates victim and counts
        if (mh !== exp_hit || (mh && mw !== exp_way))
          abort_run("Reference model and stimulus table disagree on a lookup");
        check_flags(hit_o, miss_o, exp_hit);
        if (exp_hit) check_way(hit_way_o, exp_way);
      end
      OP_FILL: begin
        fill_addr_i = data;
        fill_valid_i = 1'b1;
        model_fill(data);
      end
      OP_FLUSH: begin
        flush_i = 1'b1;
        foreach (m_vld[i]) m_vld[i] = '0;
      end
      OP_CFG_WR: begin
        cfg_addr_i = data[17:16];
        cfg_wdata_i = data[15:0];
        cfg_we_i = 1'b1;
        if (data[17:16] == 2'd0) m_en = data[3:0];
        if (data[17:16] == 2'd1) m_hits = '0;
        if (data[17:16] == 2'd2) m_misses = '0;
      end
      default: begin
        cfg_addr_i = data[17:16];
        @(posedge clk_i);
        #1;
        check_count(cfg_rdata_o, exp_rd);
      end
    endcase
    @(posedge clk_i);  // Strobe seen, or victim and counters settle
    #1;
    fill_valid_i = 1'b0;
    flush_i = 1'b0;
    cfg_we_i = 1'b0;
  endtask

  // Bound controller assertions end the run at once
  always @(DUT.u_ctrl.u_props.fail_cnt) begin
    if (DUT.u_ctrl.u_props.fail_cnt != 0)
      abort_run("A bound assertion on the lookup controller failed");
  end

  initial begin
    logic mh;
    icache_types_pkg::way_idx_t mw;
    logic [31:0] a;
    rst_n_i = 1'b0;
    {lookup_valid_i, fill_valid_i, flush_i, cfg_we_i} = '0;
    lookup_addr_i = '0;
    fill_addr_i = '0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    foreach (m_vld[i]) m_vld[i] = '0;
    m_en = '1;
    m_victim = '0;
    m_ptr = 2'd3;
    m_hits = '0;
    m_misses = '0;
    seed = 32'h12a5;

    // Reset state, then fill set 5 in way order
    add_row(OP_CFG_RD, 32'h0_0000, 0, 0, 16'h000f);
    add_row(OP_CFG_RD, 32'h1_0000, 0, 0, 16'h0000);
    add_row(OP_CFG_RD, 32'h2_0000, 0, 0, 16'h0000);
    add_row(OP_LOOKUP, mk_addr(20'habcde, 6'd9), 0, 0, 0);
    for (int k = 0; k < 4; k++) begin
      add_row(OP_LOOKUP, mk_addr(20'h1a000 + k, 6'd5), 0, 0, 0);
      add_row(OP_FILL, mk_addr(20'h1a000 + k, 6'd5), 0, 0, 0);
    end
    for (int k = 0; k < 4; k++) begin
      add_row(OP_LOOKUP, mk_addr(20'h1a000 + k, 6'd5), 1, k, 0);
    end
    // Fifth tag evicts way 0
    add_row(OP_LOOKUP, mk_addr(20'h1a004, 6'd5), 0, 0, 0);
    add_row(OP_FILL, mk_addr(20'h1a004, 6'd5), 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a000, 6'd5), 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a004, 6'd5), 1, 0, 0);
    for (int k = 1; k < 4; k++) begin
      add_row(OP_LOOKUP, mk_addr(20'h1a000 + k, 6'd5), 1, k, 0);
    end
    // Ways 1 and 2 off
    add_row(OP_CFG_WR, 32'h0_0009, 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a001, 6'd5), 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a002, 6'd5), 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a004, 6'd5), 1, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a003, 6'd5), 1, 3, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a005, 6'd6), 0, 0, 0);
    add_row(OP_FILL, mk_addr(20'h1a005, 6'd6), 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a006, 6'd6), 0, 0, 0);
    add_row(OP_FILL, mk_addr(20'h1a006, 6'd6), 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a005, 6'd6), 1, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a006, 6'd6), 1, 3, 0);
    add_row(OP_CFG_WR, 32'h0_000f, 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a001, 6'd5), 1, 1, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a002, 6'd5), 1, 2, 0);
    // Counters, flush, counter clear
    add_row(OP_CFG_RD, 32'h1_0000, 0, 0, 16'd14);
    add_row(OP_CFG_RD, 32'h2_0000, 0, 0, 16'd11);
    add_row(OP_FLUSH, 32'h0, 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a004, 6'd5), 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a001, 6'd5), 0, 0, 0);
    add_row(OP_LOOKUP, mk_addr(20'h1a005, 6'd6), 0, 0, 0);
    add_row(OP_CFG_RD, 32'h1_0000, 0, 0, 16'd14);
    add_row(OP_CFG_RD, 32'h2_0000, 0, 0, 16'd14);
    add_row(OP_CFG_WR, 32'h1_1234, 0, 0, 0);
    add_row(OP_CFG_RD, 32'h1_0000, 0, 0, 16'd0);
    add_row(OP_CFG_WR, 32'h2_5678, 0, 0, 0);
    add_row(OP_CFG_RD, 32'h2_0000, 0, 0, 16'd0);

    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #1;

    for (int r = 0; r < row_op.size(); r++)
      apply(row_op[r], row_data[r], row_hit[r], row_way[r], row_rd[r]);

    // Random lookups, a miss is mostly refilled right away
    for (int n = 0; n < 200; n++) begin
      seed = lcg_next(seed);
      a = mk_addr(20'h2b000 + seed[20:18], 6'(seed[17:16]));
      mh = 1'b0;
      mw = '0;
      for (int w = 3; w >= 0; w--) begin
        if (m_vld[a[11:6]][w] && m_en[w] && m_tag[a[11:6]][w] == a[31:12]) begin
          mh = 1'b1;
          mw = w;
        end
      end
      apply(OP_LOOKUP, a, mh, mw, 0);
      if (!mh && seed[23:22] != 2'd0) apply(OP_FILL, a, 0, 0, 0);  // Refill missed line
    end
    apply(OP_CFG_RD, 32'h1_0000, 0, 0, m_hits);
    apply(OP_CFG_RD, 32'h2_0000, 0, 0, m_misses);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: itag_lookup_top.f
+incdir+include
logic/icache_types_pkg.sv
logic/icache_cfg_pkg.sv
logic/itag_mem_if.sv
logic/tag_sram_model.sv
logic/itag_memory.sv
logic/itag_lookup_ctrl.sv
logic/itag_victim_select.sv
logic/itag_cfg_regs.sv
logic/itag_lookup_top.sv
verification/itag_lookup_props.sv
verification/itag_lookup_tb.sv

// File: Bender.yml
package:
  name: itag_lookup

sources:
  - include_dirs:
      - include
    files:
      - logic/icache_types_pkg.sv
      - logic/icache_cfg_pkg.sv
      - logic/itag_mem_if.sv
      - logic/tag_sram_model.sv
      - logic/itag_memory.sv
      - logic/itag_lookup_ctrl.sv
      - logic/itag_victim_select.sv
      - logic/itag_cfg_regs.sv
      - logic/itag_lookup_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/itag_lookup_props.sv
      - verification/itag_lookup_tb.sv
